//--- hdl/rv_core_pkg.sv
// RV32I core shared definitions
// opcodes, ALU and control select codes, and the instruction-word formats
package rv_core_pkg;

    localparam int xlen = 32;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_function_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc_plus_4
    } wb_select_t;

    typedef enum logic [1:0] {
        branch_sequential,
        branch_conditional,
        branch_jal,
        branch_jalr
    } branch_kind_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    // branch offset bits are scattered across the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
        s_type_t s_type;
        b_type_t b_type;
        u_type_t u_type;
        j_type_t j_type;
    } inst_word_t;

endpackage

//--- hdl/regfile.sv
// register file, 32 x 32 bits
// two combinational read ports, one write port, x0 reads as zero
`timescale 1ns/1ps

module regfile (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        write_enable,
    input  logic [4:0]                  rd_address,
    input  logic [4:0]                  rs1_address,
    input  logic [4:0]                  rs2_address,
    input  logic [rv_core_pkg::xlen-1:0] rd_data,
    output logic [rv_core_pkg::xlen-1:0] rs1_data,
    output logic [rv_core_pkg::xlen-1:0] rs2_data
);

    import rv_core_pkg::*;

    // x1 to x31 only
    logic [xlen-1:0] registers [31:1];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable && rd_address != 5'd0) begin
            registers[rd_address] <= rd_data;
        end
    end

    // no bypass of the write data
    assign rs1_data = (rs1_address == 5'd0) ? '0 : registers[rs1_address];
    assign rs2_data = (rs2_address == 5'd0) ? '0 : registers[rs2_address];

endmodule

//--- hdl/alu.sv
// integer ALU for the RV32I operations
// shifts take the low 5 bits of operand_b, zero flag feeds branch compare
`timescale 1ns/1ps

module alu (
    input  rv_core_pkg::alu_function_t   alu_function,
    input  logic [rv_core_pkg::xlen-1:0] operand_a,
    input  logic [rv_core_pkg::xlen-1:0] operand_b,
    output logic [rv_core_pkg::xlen-1:0] result,
    output logic                         result_equal_zero
);

    import rv_core_pkg::*;

    logic [4:0] shift_amount;

    assign shift_amount = operand_b[4:0];

    always_comb begin
        case (alu_function)
            alu_add:
                result = operand_a + operand_b;
            alu_sub:
                result = operand_a - operand_b;
            alu_sll:
                result = operand_a << shift_amount;
            alu_slt:
                result = {{(xlen-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            alu_sltu:
                result = {{(xlen-1){1'b0}}, operand_a < operand_b};
            alu_xor:
                result = operand_a ^ operand_b;
            alu_srl:
                result = operand_a >> shift_amount;
            alu_sra:
                result = $unsigned($signed(operand_a) >>> shift_amount);
            alu_or:
                result = operand_a | operand_b;
            alu_and:
                result = operand_a & operand_b;
            // lui passes the immediate straight through
            alu_pass_b:
                result = operand_b;
            default:
                result = '0;
        endcase
    end

    assign result_equal_zero = (result == '0);

endmodule

//--- hdl/instruction_decoder.sv
// RV32I instruction decoder
// splits the instruction word, builds the immediate, drives data path control
`timescale 1ns/1ps

module instruction_decoder (
    input  rv_core_pkg::inst_word_t      instruction,
    output logic [rv_core_pkg::xlen-1:0] immediate,
    output logic [4:0]                   rs1_address,
    output logic [4:0]                   rs2_address,
    output logic [4:0]                   rd_address,
    output logic                         regfile_write_enable,
    output logic                         data_write_enable,
    output logic                         operand_a_select,
    output logic                         operand_b_select,
    output rv_core_pkg::alu_function_t   alu_function,
    output rv_core_pkg::wb_select_t      wb_select,
    output rv_core_pkg::branch_kind_t    branch_kind,
    output logic [2:0]                   branch_funct3
);

    import rv_core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alternate;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    // alternate picks sub over add and sra over srl
    function automatic alu_function_t alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode        = instruction.r_type.opcode;
    assign funct3        = instruction.r_type.funct3;
    assign alternate     = instruction.r_type.funct7[5];
    assign rs1_address   = instruction.r_type.rs1;
    assign rs2_address   = instruction.r_type.rs2;
    assign rd_address    = instruction.r_type.rd;
    assign branch_funct3 = funct3;

    assign imm_i = {{20{instruction.i_type.imm_11_0[11]}}, instruction.i_type.imm_11_0};
    assign imm_s = {{20{instruction.s_type.imm_11_5[6]}}, instruction.s_type.imm_11_5,
                    instruction.s_type.imm_4_0};
    assign imm_b = {{20{instruction.b_type.imm_12}}, instruction.b_type.imm_11,
                    instruction.b_type.imm_10_5, instruction.b_type.imm_4_1, 1'b0};
    assign imm_u = {instruction.u_type.imm_31_12, 12'b0};
    assign imm_j = {{12{instruction.j_type.imm_20}}, instruction.j_type.imm_19_12,
                    instruction.j_type.imm_11, instruction.j_type.imm_10_1, 1'b0};

    always_comb begin
        // unknown opcodes retire as a no-op
        immediate            = '0;
        regfile_write_enable = 1'b0;
        data_write_enable    = 1'b0;
        operand_a_select     = 1'b0;
        operand_b_select     = 1'b1;
        alu_function         = alu_add;
        wb_select            = wb_alu;
        branch_kind          = branch_sequential;
        case (opcode)
            op_lui: begin
                immediate            = imm_u;
                regfile_write_enable = 1'b1;
                alu_function         = alu_pass_b;
            end
            op_auipc: begin
                immediate            = imm_u;
                regfile_write_enable = 1'b1;
                operand_a_select     = 1'b1;
            end
            op_jal: begin
                immediate            = imm_j;
                regfile_write_enable = 1'b1;
                wb_select            = wb_pc_plus_4;
                branch_kind          = branch_jal;
            end
            op_jalr: begin
                immediate            = imm_i;
                regfile_write_enable = 1'b1;
                wb_select            = wb_pc_plus_4;
                branch_kind          = branch_jalr;
            end
            op_branch: begin
                immediate        = imm_b;
                operand_b_select = 1'b0;
                branch_kind      = branch_conditional;
                // compare by sub for eq/ne, by slt/sltu for the ordered tests
                case (funct3[2:1])
                    2'b10:   alu_function = alu_slt;
                    2'b11:   alu_function = alu_sltu;
                    default: alu_function = alu_sub;
                endcase
            end
            op_load: begin
                immediate            = imm_i;
                regfile_write_enable = 1'b1;
                wb_select            = wb_load;
            end
            op_store: begin
                immediate         = imm_s;
                data_write_enable = 1'b1;
            end
            op_imm: begin
                immediate            = imm_i;
                regfile_write_enable = 1'b1;
                alu_function = alu_from_funct3(funct3, alternate && funct3 == 3'b101);
            end
            op_reg: begin
                regfile_write_enable = 1'b1;
                operand_b_select     = 1'b0;
                alu_function         = alu_from_funct3(funct3, alternate);
            end
            default: begin
                branch_kind = branch_sequential;
            end
        endcase
    end

endmodule

//--- hdl/singlecycle_datapath.sv
// single-cycle data path
// pc register, next-pc and branch resolution, operand and writeback muxes
`timescale 1ns/1ps

module singlecycle_datapath (
    input  logic                         clock,
    input  logic                         arst_n,
    output logic [rv_core_pkg::xlen-1:0] instruction_address,
    input  logic [rv_core_pkg::xlen-1:0] data_read_data,
    output logic [rv_core_pkg::xlen-1:0] data_address,
    output logic [rv_core_pkg::xlen-1:0] data_write_data,
    input  logic [rv_core_pkg::xlen-1:0] immediate,
    input  logic [4:0]                   rs1_address,
    input  logic [4:0]                   rs2_address,
    input  logic [4:0]                   rd_address,
    input  logic                         regfile_write_enable,
    input  logic                         operand_a_select,
    input  logic                         operand_b_select,
    input  rv_core_pkg::alu_function_t   alu_function,
    input  rv_core_pkg::wb_select_t      wb_select,
    input  rv_core_pkg::branch_kind_t    branch_kind,
    input  logic [2:0]                   branch_funct3
);

    import rv_core_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] pc_plus_4;
    logic [xlen-1:0] pc_plus_immediate;

    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] rd_data;

    logic [xlen-1:0] alu_operand_a;
    logic [xlen-1:0] alu_operand_b;
    logic [xlen-1:0] alu_result;
    logic            alu_result_equal_zero;

    logic            condition;
    logic            branch_taken;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign instruction_address = pc;
    assign pc_plus_4           = pc + xlen'(4);
    assign pc_plus_immediate   = pc + immediate;

    assign alu_operand_a = operand_a_select ? pc : rs1_data;
    assign alu_operand_b = operand_b_select ? immediate : rs2_data;

    assign data_address    = alu_result;
    assign data_write_data = rs2_data;

    // funct3[2] set means an ordered compare, slt result nonzero when less
    // funct3[0] inverts for bne, bge and bgeu
    assign condition    = branch_funct3[2] ? !alu_result_equal_zero : alu_result_equal_zero;
    assign branch_taken = (branch_funct3[2:1] != 2'b01) && (condition ^ branch_funct3[0]);

    always_comb begin
        case (branch_kind)
            branch_conditional: next_pc = branch_taken ? pc_plus_immediate : pc_plus_4;
            branch_jal:         next_pc = pc_plus_immediate;
            branch_jalr:        next_pc = {alu_result[xlen-1:1], 1'b0};
            default:            next_pc = pc_plus_4;
        endcase
    end

    always_comb begin
        case (wb_select)
            wb_load:      rd_data = data_read_data;
            wb_pc_plus_4: rd_data = pc_plus_4;
            default:      rd_data = alu_result;
        endcase
    end

    regfile regfile (
        .clock        (clock),
        .arst_n       (arst_n),
        .write_enable (regfile_write_enable),
        .rd_address   (rd_address),
        .rs1_address  (rs1_address),
        .rs2_address  (rs2_address),
        .rd_data      (rd_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    alu alu (
        .alu_function      (alu_function),
        .operand_a         (alu_operand_a),
        .operand_b         (alu_operand_b),
        .result            (alu_result),
        .result_equal_zero (alu_result_equal_zero)
    );

endmodule

//--- hdl/simple_core.sv
// single-cycle RV32I core top level
// joins the decoder and the data path to the instruction and data memory ports
`timescale 1ns/1ps

module simple_core (
    input  logic                         clock,
    input  logic                         arst_n,
    output logic [rv_core_pkg::xlen-1:0] pc,
    input  logic [rv_core_pkg::xlen-1:0] instruction,
    output logic [rv_core_pkg::xlen-1:0] data_address,
    output logic [rv_core_pkg::xlen-1:0] data_write_data,
    output logic                         data_write_enable,
    input  logic [rv_core_pkg::xlen-1:0] data_read_data
);

    import rv_core_pkg::*;

    // decoder to data path control
    logic [xlen-1:0] immediate;
    logic [4:0]      rs1_address;
    logic [4:0]      rs2_address;
    logic [4:0]      rd_address;
    logic            regfile_write_enable;
    logic            store_enable;
    logic            operand_a_select;
    logic            operand_b_select;
    alu_function_t   alu_function;
    wb_select_t      wb_select;
    branch_kind_t    branch_kind;
    logic [2:0]      branch_funct3;

    // no memory write while the core is held in reset
    assign data_write_enable = store_enable && arst_n;

    instruction_decoder instruction_decoder (
        .instruction          (instruction),
        .immediate            (immediate),
        .rs1_address          (rs1_address),
        .rs2_address          (rs2_address),
        .rd_address           (rd_address),
        .regfile_write_enable (regfile_write_enable),
        .data_write_enable    (store_enable),
        .operand_a_select     (operand_a_select),
        .operand_b_select     (operand_b_select),
        .alu_function         (alu_function),
        .wb_select            (wb_select),
        .branch_kind          (branch_kind),
        .branch_funct3        (branch_funct3)
    );

    singlecycle_datapath singlecycle_datapath (
        .clock                (clock),
        .arst_n               (arst_n),
        .instruction_address  (pc),
        .data_read_data       (data_read_data),
        .data_address         (data_address),
        .data_write_data      (data_write_data),
        .immediate            (immediate),
        .rs1_address          (rs1_address),
        .rs2_address          (rs2_address),
        .rd_address           (rd_address),
        .regfile_write_enable (regfile_write_enable),
        .operand_a_select     (operand_a_select),
        .operand_b_select     (operand_b_select),
        .alu_function         (alu_function),
        .wb_select            (wb_select),
        .branch_kind          (branch_kind),
        .branch_funct3        (branch_funct3)
    );

endmodule

//--- tb/simple_core_assert.sv
// port checks for the single-cycle core, bound into simple_core
`timescale 1ns/1ps

module simple_core_assert (
    input logic                         clock,
    input logic                         arst_n,
    input logic [rv_core_pkg::xlen-1:0] pc,
    input logic [rv_core_pkg::xlen-1:0] instruction,
    input logic                         data_write_enable
);

    import rv_core_pkg::*;

    no_write_in_reset: assert property (@(posedge clock) !arst_n |-> !data_write_enable)
        else $error("data_write_enable high while in reset");

    // only a store may write the data memory
    write_only_on_store: assert property (@(posedge clock) disable iff (!arst_n)
        data_write_enable |-> instruction[6:0] == op_store)
        else $error("data_write_enable high for a non-store opcode");

    pc_known: assert property (@(posedge clock) disable iff (!arst_n) !$isunknown(pc))
        else $error("pc unknown after reset");

endmodule

bind simple_core simple_core_assert assertions (
    .clock             (clock),
    .arst_n            (arst_n),
    .pc                (pc),
    .instruction       (instruction),
    .data_write_enable (data_write_enable)
);

//--- tb/simple_core_tb.sv
// testbench for the single-cycle RV32I core
// random program in a ROM model, data RAM model, and a reference ISA model
`timescale 1ns/1ps

module simple_core_tb;

    import rv_core_pkg::*;

    localparam int rom_words        = 64;
    localparam int reset_cycles     = 8;
    localparam int num_instructions = 2000;
    localparam int cycle_limit      = num_instructions + reset_cycles + 100;

    logic        clock;
    logic        arst_n;
    logic [31:0] pc;
    logic [31:0] instruction;
    logic [31:0] data_address;
    logic [31:0] data_write_data;
    logic        data_write_enable;
    logic [31:0] data_read_data;

    // memories seen by the DUT
    logic [31:0] rom [rom_words];
    logic [31:0] mem_ram [64];

    // reference model state
    logic [31:0] model_pc;
    logic [31:0] model_regs [32];
    logic [31:0] model_ram [64];

    // memory access expected from the instruction at model_pc
    logic        expect_store;
    logic        expect_load;
    logic [31:0] expect_address;
    logic [31:0] expect_store_data;

    logic        seen_write_enable;
    logic [31:0] seen_address;
    logic [31:0] seen_write_data;

    int cycle_count  = 0;
    int commit_count = 0;
    int store_count  = 0;
    int load_count   = 0;
    int taken_count  = 0;

    simple_core dut (
        .clock             (clock),
        .arst_n            (arst_n),
        .pc                (pc),
        .instruction       (instruction),
        .data_address      (data_address),
        .data_write_data   (data_write_data),
        .data_write_enable (data_write_enable),
        .data_read_data    (data_read_data)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // nonzero multiple of 4 in -64..60
    function automatic int random_offset();
        int offset;
        offset = ($urandom_range(31, 0) - 16) * 4;
        if (offset == 0) begin
            offset = 4;
        end
        return offset;
    endfunction

    task automatic fill_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [12:0] boff;
        logic [20:0] joff;
        logic        alt;
        logic [2:0]  conditions [6];
        int          kind;
        conditions = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int i = 0; i < rom_words; i++) begin
            rd    = 5'($urandom);
            rs1   = 5'($urandom);
            rs2   = 5'($urandom);
            f3    = 3'($urandom);
            imm12 = 12'($urandom);
            alt   = 1'($urandom);
            boff  = 13'(random_offset());
            joff  = 21'(random_offset());
            // warm up the registers with addi and lui only
            if (i < 16) begin
                kind = (($urandom % 2) == 0) ? 10 : 0;
            end else begin
                kind = $urandom % 13;
            end
            case (kind)
                0:
                    rom[i] = {20'($urandom), rd, op_lui};
                1:
                    rom[i] = {20'($urandom), rd, op_auipc};
                2:
                    rom[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, op_jal};
                3:
                    rom[i] = {imm12, rs1, 3'b000, rd, op_jalr};
                4, 5:
                    rom[i] = {boff[12], boff[10:5], rs2, rs1, conditions[$urandom % 6],
                              boff[4:1], boff[11], op_branch};
                6, 7:
                    rom[i] = {imm12, rs1, 3'b010, rd, op_load};
                8, 9:
                    rom[i] = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], op_store};
                10, 11: begin
                    if (i < 16) begin
                        f3 = 3'b000;
                    end
                    // shift immediates carry only shamt and the sra bit
                    if (f3 == 3'b001) begin
                        imm12 = {7'b0, imm12[4:0]};
                    end else if (f3 == 3'b101) begin
                        imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
                    end
                    rom[i] = {imm12, rs1, f3, rd, op_imm};
                end
                default: begin
                    alt = alt && (f3 == 3'b000 || f3 == 3'b101);
                    rom[i] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
                end
            endcase
        end
    endtask

    function automatic logic [31:0] integer_op(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:
                return alt ? a - b : a + b;
            3'b001:
                return a << b[4:0];
            3'b010:
                return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:
                return (a < b) ? 32'd1 : 32'd0;
            3'b100:
                return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> b[4:0]);
                end
                return a >> b[4:0];
            end
            3'b110:
                return a | b;
            default:
                return a & b;
        endcase
    endfunction

    task automatic step_model();
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_u;
        logic [31:0] address;
        logic [31:0] result;
        logic [31:0] next_pc;
        logic [2:0]  f3;
        logic        write_rd;
        logic        taken;
        word     = rom[model_pc[7:2]];
        f3       = word[14:12];
        a        = model_regs[word[19:15]];
        b        = model_regs[word[24:20]];
        imm_i    = {{20{word[31]}}, word[31:20]};
        imm_s    = {{20{word[31]}}, word[31:25], word[11:7]};
        imm_b    = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        imm_j    = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        imm_u    = {word[31:12], 12'b0};
        result   = '0;
        write_rd = 1'b0;
        taken    = 1'b0;
        next_pc  = model_pc + 32'd4;
        case (word[6:0])
            op_lui: begin
                result   = imm_u;
                write_rd = 1'b1;
            end
            op_auipc: begin
                result   = model_pc + imm_u;
                write_rd = 1'b1;
            end
            op_jal: begin
                result   = model_pc + 32'd4;
                write_rd = 1'b1;
                taken    = 1'b1;
                next_pc  = model_pc + imm_j;
            end
            op_jalr: begin
                result   = model_pc + 32'd4;
                write_rd = 1'b1;
                taken    = 1'b1;
                next_pc  = (a + imm_i) & ~32'd1;
            end
            op_branch: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = model_pc + imm_b;
                end
            end
            op_load: begin
                address  = a + imm_i;
                result   = model_ram[address[7:2]];
                write_rd = 1'b1;
                load_count++;
            end
            op_store: begin
                address = a + imm_s;
                model_ram[address[7:2]] = b;
                store_count++;
            end
            op_imm: begin
                result   = integer_op(f3, f3 == 3'b101 && word[30], a, imm_i);
                write_rd = 1'b1;
            end
            op_reg: begin
                result   = integer_op(f3, word[30], a, b);
                write_rd = 1'b1;
            end
            default: begin
                write_rd = 1'b0;
            end
        endcase
        if (write_rd && word[11:7] != 5'd0) begin
            model_regs[word[11:7]] = result;
        end
        if (taken) begin
            taken_count++;
        end
        model_pc = next_pc;
    endtask

    task automatic predict_access();
        logic [31:0] word;
        logic [31:0] offset;
        word         = rom[model_pc[7:2]];
        expect_store = (word[6:0] == op_store);
        expect_load  = (word[6:0] == op_load);
        if (expect_store) begin
            offset = {{20{word[31]}}, word[31:25], word[11:7]};
        end else begin
            offset = {{20{word[31]}}, word[31:20]};
        end
        expect_address    = model_regs[word[19:15]] + offset;
        expect_store_data = model_regs[word[24:20]];
    endtask

    task automatic check_outputs();
        check_value("pc", model_pc, pc);
        if (expect_store) begin
            check_value("data_write_enable", 32'd1, {31'b0, data_write_enable});
            check_value("store address", {26'b0, expect_address[7:2]},
                        {26'b0, data_address[7:2]});
            check_value("store data", expect_store_data, data_write_data);
        end else begin
            check_value("data_write_enable", 32'd0, {31'b0, data_write_enable});
        end
        if (expect_load) begin
            check_value("load address", {26'b0, expect_address[7:2]},
                        {26'b0, data_address[7:2]});
        end
        seen_write_enable = data_write_enable;
        seen_address      = data_address;
        seen_write_data   = data_write_data;
    endtask

    // runs on the rising edge, before the DUT state moves
    task automatic commit_cycle();
        if (seen_write_enable) begin
            mem_ram[seen_address[7:2]] = seen_write_data;
        end
        step_model();
        predict_access();
        instruction <= rom[model_pc[7:2]];
        if (expect_load) begin
            data_read_data <= mem_ram[expect_address[7:2]];
        end else begin
            data_read_data <= $urandom;
        end
        commit_count++;
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: only %0d of %0d instructions committed in %0d cycles",
                     commit_count, num_instructions, cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        void'($urandom(32'hd903fc73));
        fill_program();
        for (int i = 0; i < 64; i++) begin
            model_ram[i] = 32'hda00_0000 + i * 32'h0001_0203;
            mem_ram[i]   = model_ram[i];
            model_regs[i % 32] = '0;
        end
        model_pc = '0;
        seen_write_enable = 1'b0;
        seen_address      = '0;
        seen_write_data   = '0;
        predict_access();

        // a store word sits on the bus while reset is held
        arst_n         <= 1'b0;
        instruction    <= {7'b0, 5'd0, 5'd0, 3'b010, 5'd0, op_store};
        data_read_data <= '0;

        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clock);
            if (i == reset_cycles - 1) begin
                arst_n      <= 1'b1;
                instruction <= rom[0];
            end
            @(negedge clock);
            check_value("reset pc", 32'd0, pc);
            check_value("reset data_write_enable", 32'd0, {31'b0, data_write_enable});
        end

        repeat (num_instructions) begin
            check_outputs();
            @(posedge clock);
            commit_cycle();
            @(negedge clock);
        end
        check_outputs();

        $display("%0d instructions, %0d stores, %0d loads, %0d taken transfers",
                 commit_count, store_count, load_count, taken_count);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- sim.f
hdl/rv_core_pkg.sv
hdl/regfile.sv
hdl/alu.sv
hdl/instruction_decoder.sv
hdl/singlecycle_datapath.sv
hdl/simple_core.sv
tb/simple_core_assert.sv
tb/simple_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the simple_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module simple_core_tb \
    -f sim.f \
    -o simple_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/simple_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
